/* logic/ram_ctrl_pkg.sv */
// Slot state enum, SRAM widths and address region prefixes
`default_nettype none

package ram_ctrl_pkg;

   // Shared address bus and microcode word widths of the board
   localparam int SRAM_AW = 18;
   localparam int MCR_W   = 52;

   // Top address bits of each client region
   localparam logic [4:0] MCR_REGION   = 5'b01000;
   localparam logic [1:0] SDRAM_REGION = 2'b00;
   localparam logic [1:0] VRAM_REGION  = 2'b11;

   // One slot per clock
   typedef enum logic [3:0] {
      SLOT_IDLE     = 4'd0,
      SLOT_MCR_RD1  = 4'd1,
      SLOT_MCR_RD2  = 4'd2,
      SLOT_MCR_WR1  = 4'd3,
      SLOT_MCR_WR2  = 4'd4,
      SLOT_SDRAM_RD = 4'd5,
      SLOT_SDRAM_WR = 4'd6,
      SLOT_VRAM_RD  = 4'd7,
      SLOT_VRAM_WR  = 4'd8
   } slot_t;

endpackage

`default_nettype wire

/* logic/slot_scheduler.sv */
// Slot FSM with service priority and client ready and done strobes
`timescale 1ns/1ps
`default_nettype none

module slot_scheduler (
   input  wire                  clk,
   input  wire                  reset,
   input  wire                  mcr_write,
   input  wire                  sdram_req,
   input  wire                  sdram_write,
   input  wire                  vram_req,
   input  wire                  vram_write,
   output ram_ctrl_pkg::slot_t  slot,
   output logic                 mcr_ready,
   output logic                 mcr_done,
   output logic                 sdram_ready,
   output logic                 sdram_done,
   output logic                 vram_ready,
   output logic                 vram_done
);

   import ram_ctrl_pkg::*;

   slot_t next_slot;

   always_ff @(posedge clk) begin
      if (reset) begin
         slot <= SLOT_IDLE;
      end else begin
         slot <= next_slot;
      end
   end

   // Microcode reads always run, then at most one service slot
   always_comb begin
      next_slot = SLOT_IDLE;
      case (slot)
         SLOT_IDLE: next_slot = SLOT_MCR_RD1;
         SLOT_MCR_RD1: next_slot = SLOT_MCR_RD2;
         SLOT_MCR_RD2: begin
            if (mcr_write) begin
               next_slot = SLOT_MCR_WR1;
            end else if (sdram_req) begin
               next_slot = SLOT_SDRAM_RD;
            end else if (sdram_write) begin
               next_slot = SLOT_SDRAM_WR;
            end else if (vram_req) begin
               next_slot = SLOT_VRAM_RD;
            end else if (vram_write) begin
               next_slot = SLOT_VRAM_WR;
            end
         end
         SLOT_MCR_WR1: next_slot = SLOT_MCR_WR2;
         default: next_slot = SLOT_IDLE;
      endcase
   end

   assign mcr_ready   = (slot == SLOT_MCR_RD2);
   assign mcr_done    = (slot == SLOT_MCR_WR1);
   assign sdram_ready = (slot == SLOT_SDRAM_RD);
   assign sdram_done  = (slot == SLOT_SDRAM_WR);
   assign vram_ready  = (slot == SLOT_VRAM_RD);
   assign vram_done   = (slot == SLOT_VRAM_WR);

   // Clients see a single event per cycle
   a_one_strobe: assert property (@(posedge clk) disable iff (reset)
      $onehot0({mcr_ready, mcr_done, sdram_ready, sdram_done, vram_ready, vram_done}));

   // Second microcode beat never gets skipped
   a_rd1_then_rd2: assert property (@(posedge clk) disable iff (reset)
      (slot == SLOT_MCR_RD1) |=> (slot == SLOT_MCR_RD2));

endmodule

`default_nettype wire

/* logic/mcr_beat_unit.sv */
// Microcode beat addressing, write half selection and read word assembly
`timescale 1ns/1ps
`default_nettype none

module mcr_beat_unit (
   input  wire                                  clk,
   input  wire                                  reset,
   input  ram_ctrl_pkg::slot_t                  slot,
   input  wire  [11:0]                          mcr_addr,
   input  wire  [ram_ctrl_pkg::MCR_W-1:0]       mcr_data_in,
   input  wire  [15:0]                          rd1,
   input  wire  [15:0]                          rd2,
   output logic [ram_ctrl_pkg::SRAM_AW-1:0]     mcr_a,
   output logic [15:0]                          mcr_wdata1,
   output logic [15:0]                          mcr_wdata2,
   output logic [ram_ctrl_pkg::MCR_W-1:0]       mcr_data_out
);

   import ram_ctrl_pkg::*;

   logic        second_beat;
   logic        first_wr;
   // Only bits 51 to 32 of the word come back in the first beat
   logic [19:0] mcr_hold;

   assign second_beat = (slot == SLOT_MCR_RD2) || (slot == SLOT_MCR_WR2);
   assign first_wr    = (slot == SLOT_MCR_WR1);

   assign mcr_a = {MCR_REGION, mcr_addr, second_beat};

   // First beat carries the top 20 bits, upper chip zero padded
   always_comb begin
      if (first_wr) begin
         mcr_wdata1 = {12'b0, mcr_data_in[51:48]};
         mcr_wdata2 = mcr_data_in[47:32];
      end else begin
         mcr_wdata1 = mcr_data_in[31:16];
         mcr_wdata2 = mcr_data_in[15:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mcr_hold <= '0;
      end else if (slot == SLOT_MCR_RD1) begin
         mcr_hold <= {rd1[3:0], rd2};
      end
   end

   // Word is valid only while the second beat is on the bus
   assign mcr_data_out = (slot == SLOT_MCR_RD2) ? {mcr_hold, rd1, rd2} : '0;

endmodule

`default_nettype wire

/* logic/word_port_unit.sv */
// Region mapping, write data split and read data gating for sdram and vram ports
`timescale 1ns/1ps
`default_nettype none

module word_port_unit (
   input  ram_ctrl_pkg::slot_t                  slot,
   input  wire  [17:0]                          sdram_addr,
   input  wire  [31:0]                          sdram_data_in,
   input  wire  [14:0]                          vram_addr,
   input  wire  [31:0]                          vram_data_in,
   input  wire  [15:0]                          rd1,
   input  wire  [15:0]                          rd2,
   output logic [ram_ctrl_pkg::SRAM_AW-1:0]     word_a,
   output logic [15:0]                          word_wdata1,
   output logic [15:0]                          word_wdata2,
   output logic [31:0]                          sdram_data_out,
   output logic [31:0]                          vram_data_out
);

   import ram_ctrl_pkg::*;

   logic        vram_owns;
   logic [31:0] wr_word;
   logic [31:0] rd_word;

   // sdram owns the port unless a vram slot is running
   assign vram_owns = (slot == SLOT_VRAM_RD) || (slot == SLOT_VRAM_WR);

   // sdram only reaches the low 32K words of its region
   always_comb begin
      if (vram_owns) begin
         word_a  = {VRAM_REGION, 1'b0, vram_addr};
         wr_word = vram_data_in;
      end else begin
         word_a  = {SDRAM_REGION, 1'b0, sdram_addr[14:0]};
         wr_word = sdram_data_in;
      end
   end

   // Chip 1 holds the high half
   assign word_wdata1 = wr_word[31:16];
   assign word_wdata2 = wr_word[15:0];

   assign rd_word = {rd1, rd2};

   assign sdram_data_out = (slot == SLOT_SDRAM_RD) ? rd_word : 32'b0;
   assign vram_data_out  = (slot == SLOT_VRAM_RD) ? rd_word : 32'b0;

endmodule

`default_nettype wire

/* logic/sram_bus_combiner.sv */
// SRAM pin drive from the microcode and word sources, strobes and tristate data buses
`timescale 1ns/1ps
`default_nettype none

module sram_bus_combiner (
   input  ram_ctrl_pkg::slot_t                  slot,
   input  wire  [ram_ctrl_pkg::SRAM_AW-1:0]     mcr_a,
   input  wire  [15:0]                          mcr_wdata1,
   input  wire  [15:0]                          mcr_wdata2,
   input  wire  [ram_ctrl_pkg::SRAM_AW-1:0]     word_a,
   input  wire  [15:0]                          word_wdata1,
   input  wire  [15:0]                          word_wdata2,
   output logic [15:0]                          rd1,
   output logic [15:0]                          rd2,
   output logic [ram_ctrl_pkg::SRAM_AW-1:0]     sram_a,
   output logic                                 sram_oe_n,
   output logic                                 sram_we_n,
   output logic                                 sram1_ce_n,
   output logic                                 sram1_ub_n,
   output logic                                 sram1_lb_n,
   output logic                                 sram2_ce_n,
   output logic                                 sram2_ub_n,
   output logic                                 sram2_lb_n,
   inout  wire  [15:0]                          sram1_io,
   inout  wire  [15:0]                          sram2_io
);

   import ram_ctrl_pkg::*;

   logic        mcr_slot;
   logic        rd_slot;
   logic        wr_slot;
   logic        active;
   logic [15:0] wdata1;
   logic [15:0] wdata2;

   assign mcr_slot = (slot == SLOT_MCR_RD1) || (slot == SLOT_MCR_RD2) ||
                     (slot == SLOT_MCR_WR1) || (slot == SLOT_MCR_WR2);
   assign rd_slot  = (slot == SLOT_MCR_RD1) || (slot == SLOT_MCR_RD2) ||
                     (slot == SLOT_SDRAM_RD) || (slot == SLOT_VRAM_RD);
   assign wr_slot  = (slot == SLOT_MCR_WR1) || (slot == SLOT_MCR_WR2) ||
                     (slot == SLOT_SDRAM_WR) || (slot == SLOT_VRAM_WR);
   assign active   = (slot != SLOT_IDLE);

   // Address parks at zero in idle
   assign sram_a = !active ? '0 : (mcr_slot ? mcr_a : word_a);
   assign wdata1 = mcr_slot ? mcr_wdata1 : word_wdata1;
   assign wdata2 = mcr_slot ? mcr_wdata2 : word_wdata2;

   assign sram_oe_n = !rd_slot;
   assign sram_we_n = !wr_slot;

   // Both chips always move together, full 16-bit lanes
   assign sram1_ce_n = !active;
   assign sram1_ub_n = !active;
   assign sram1_lb_n = !active;
   assign sram2_ce_n = !active;
   assign sram2_ub_n = !active;
   assign sram2_lb_n = !active;

   assign sram1_io = wr_slot ? wdata1 : 16'bz;
   assign sram2_io = wr_slot ? wdata2 : 16'bz;

   assign rd1 = sram1_io;
   assign rd2 = sram2_io;

   // Bus contention with the SRAM outputs
   always_comb begin
      assert (sram_oe_n || sram_we_n)
         else $error("output enable and write enable low together");
   end

endmodule

`default_nettype wire

/* logic/ram_controller.sv */
// Shared SRAM controller top with scheduler, microcode unit, word unit and bus combiner
`timescale 1ns/1ps
`default_nettype none

module ram_controller (
   input  wire         clk,
   input  wire         reset,

   input  wire  [11:0] mcr_addr,
   output logic [51:0] mcr_data_out,
   input  wire  [51:0] mcr_data_in,
   output logic        mcr_ready,
   input  wire         mcr_write,
   output logic        mcr_done,

   input  wire  [17:0] sdram_addr,
   output logic [31:0] sdram_data_out,
   input  wire  [31:0] sdram_data_in,
   output logic        sdram_ready,
   input  wire         sdram_req,
   input  wire         sdram_write,
   output logic        sdram_done,

   input  wire  [14:0] vram_addr,
   output logic [31:0] vram_data_out,
   input  wire  [31:0] vram_data_in,
   output logic        vram_ready,
   input  wire         vram_req,
   input  wire         vram_write,
   output logic        vram_done,

   output logic [17:0] sram_a,
   output logic        sram_oe_n,
   output logic        sram_we_n,
   inout  wire  [15:0] sram1_io,
   output logic        sram1_ce_n,
   output logic        sram1_ub_n,
   output logic        sram1_lb_n,
   inout  wire  [15:0] sram2_io,
   output logic        sram2_ce_n,
   output logic        sram2_ub_n,
   output logic        sram2_lb_n
);

   import ram_ctrl_pkg::*;

   slot_t               slot;
   logic [SRAM_AW-1:0]  mcr_a;
   logic [SRAM_AW-1:0]  word_a;
   logic [15:0]         mcr_wdata1;
   logic [15:0]         mcr_wdata2;
   logic [15:0]         word_wdata1;
   logic [15:0]         word_wdata2;
   logic [15:0]         rd1;
   logic [15:0]         rd2;

   slot_scheduler u_sched (
      .clk         (clk),
      .reset       (reset),
      .mcr_write   (mcr_write),
      .sdram_req   (sdram_req),
      .sdram_write (sdram_write),
      .vram_req    (vram_req),
      .vram_write  (vram_write),
      .slot        (slot),
      .mcr_ready   (mcr_ready),
      .mcr_done    (mcr_done),
      .sdram_ready (sdram_ready),
      .sdram_done  (sdram_done),
      .vram_ready  (vram_ready),
      .vram_done   (vram_done)
   );

   mcr_beat_unit u_mcr (
      .clk          (clk),
      .reset        (reset),
      .slot         (slot),
      .mcr_addr     (mcr_addr),
      .mcr_data_in  (mcr_data_in),
      .rd1          (rd1),
      .rd2          (rd2),
      .mcr_a        (mcr_a),
      .mcr_wdata1   (mcr_wdata1),
      .mcr_wdata2   (mcr_wdata2),
      .mcr_data_out (mcr_data_out)
   );

   word_port_unit u_word (
      .slot           (slot),
      .sdram_addr     (sdram_addr),
      .sdram_data_in  (sdram_data_in),
      .vram_addr      (vram_addr),
      .vram_data_in   (vram_data_in),
      .rd1            (rd1),
      .rd2            (rd2),
      .word_a         (word_a),
      .word_wdata1    (word_wdata1),
      .word_wdata2    (word_wdata2),
      .sdram_data_out (sdram_data_out),
      .vram_data_out  (vram_data_out)
   );

   sram_bus_combiner u_bus (
      .slot        (slot),
      .mcr_a       (mcr_a),
      .mcr_wdata1  (mcr_wdata1),
      .mcr_wdata2  (mcr_wdata2),
      .word_a      (word_a),
      .word_wdata1 (word_wdata1),
      .word_wdata2 (word_wdata2),
      .rd1         (rd1),
      .rd2         (rd2),
      .sram_a      (sram_a),
      .sram_oe_n   (sram_oe_n),
      .sram_we_n   (sram_we_n),
      .sram1_ce_n  (sram1_ce_n),
      .sram1_ub_n  (sram1_ub_n),
      .sram1_lb_n  (sram1_lb_n),
      .sram2_ce_n  (sram2_ce_n),
      .sram2_ub_n  (sram2_ub_n),
      .sram2_lb_n  (sram2_lb_n),
      .sram1_io    (sram1_io),
      .sram2_io    (sram2_io)
   );

endmodule

`default_nettype wire

/* tb/sram_model.sv */
// Behavioral dual 16-bit asynchronous SRAM on one shared 18-bit address bus
`timescale 1ns/1ps
`default_nettype none

module sram_model (
   input  wire  [17:0] sram_a,
   input  wire         sram_oe_n,
   input  wire         sram_we_n,
   input  wire         sram1_ce_n,
   input  wire         sram1_ub_n,
   input  wire         sram1_lb_n,
   input  wire         sram2_ce_n,
   input  wire         sram2_ub_n,
   input  wire         sram2_lb_n,
   inout  wire  [15:0] sram1_io,
   inout  wire  [15:0] sram2_io
);

   logic [15:0] mem1 [0:262143];
   logic [15:0] mem2 [0:262143];
   logic        sel1;
   logic        sel2;

   assign sel1 = !sram1_ce_n && !sram1_ub_n && !sram1_lb_n;
   assign sel2 = !sram2_ce_n && !sram2_ub_n && !sram2_lb_n;

   // Power-up contents follow the whole address
   initial begin
      logic [17:0] av;
      for (int i = 0; i < 262144; i++) begin
         av = i[17:0];
         mem1[i] = {av[1:0], av[15:2]} ^ {14'h0, av[17:16]} ^ 16'ha5c3;
         mem2[i] = av[15:0] ^ {av[17:16], 14'h0};
      end
   end

   assign sram1_io = (sel1 && !sram_oe_n && sram_we_n) ? mem1[sram_a] : 16'bz;
   assign sram2_io = (sel2 && !sram_oe_n && sram_we_n) ? mem2[sram_a] : 16'bz;

   // Write once the pins have settled after a change
   always begin
      @(sram_a or sram_we_n or sram1_io or sram2_io or sel1 or sel2);
      #1;
      if (!sram_we_n && sel1) mem1[sram_a] = sram1_io;
      if (!sram_we_n && sel2) mem2[sram_a] = sram2_io;
   end

endmodule

`default_nettype wire

/* tb/ram_controller_tb.sv */
// Testbench for ram_controller with SRAM model, reference memory, checker and timeout
`timescale 1ns/1ps
`default_nettype none

module ram_controller_tb;

   localparam logic [4:0] MCR_PFX   = 5'b01000;
   localparam logic [1:0] SDRAM_PFX = 2'b00;
   localparam logic [1:0] VRAM_PFX  = 2'b11;
   localparam int WAIT_MAX  = 20;
   localparam int TOTAL_OPS = 16 + 12 + 3 + 200;
   // Idle cadence run plus about 8 cycles per operation with a margin of two
   localparam int CYCLE_LIMIT = (40 + TOTAL_OPS * 8) * 2;

   logic clk, reset;
   logic [11:0] mcr_addr;
   logic [51:0] mcr_data_in, mcr_data_out;
   logic mcr_ready, mcr_write, mcr_done;
   logic [17:0] sdram_addr;
   logic [31:0] sdram_data_in, sdram_data_out;
   logic sdram_ready, sdram_req, sdram_write, sdram_done;
   logic [14:0] vram_addr;
   logic [31:0] vram_data_in, vram_data_out;
   logic vram_ready, vram_req, vram_write, vram_done;
   logic [17:0] sram_a;
   logic sram_oe_n, sram_we_n;
   logic sram1_ce_n, sram1_ub_n, sram1_lb_n, sram2_ce_n, sram2_ub_n, sram2_lb_n;
   wire  [15:0] sram1_io, sram2_io;

   logic [31:0] shadow [0:262143];
   string  test_name;
   integer seed;
   int     errors, checks, cycle_count, test_err_start, event_seq;
   int     mcr_order, sdram_order, vram_order;
   logic   mcr_check_en;

   ram_controller uut (.*);

   sram_model u_sram (.*);

   always #2 clk = ~clk;

   function automatic logic [17:0] mcr_map(input logic [11:0] a, input logic beat);
      return {MCR_PFX, a, beat};
   endfunction

   function automatic logic [17:0] sdram_map(input logic [17:0] a);
      return {SDRAM_PFX, 1'b0, a[14:0]};
   endfunction

   function automatic logic [17:0] vram_map(input logic [14:0] a);
      return {VRAM_PFX, 1'b0, a};
   endfunction

   // Chip 1 in the high half, chip 2 in the low half
   function automatic logic [31:0] expected_read(input logic [17:0] address);
      return shadow[address];
   endfunction

   function automatic logic [51:0] expected_mcr(input logic [11:0] a);
      logic [31:0] b0;
      logic [31:0] b1;
      b0 = expected_read(mcr_map(a, 1'b0));
      b1 = expected_read(mcr_map(a, 1'b1));
      return {b0[19:0], b1};
   endfunction

   task automatic report_value(input string what, input logic [63:0] exp, input logic [63:0] act);
      $display("ERR %s %s expected %h got %h", test_name, what, exp, act);
      errors++;
   endtask

   // Compares every read output in mid-cycle
   always @(negedge clk) begin
      if (!reset) begin
         if (mcr_ready && mcr_check_en) begin
            checks++;
            if (mcr_data_out !== expected_mcr(mcr_addr))
               report_value("mcr_data_out", {12'b0, expected_mcr(mcr_addr)}, {12'b0, mcr_data_out});
         end
         if (!mcr_ready && mcr_data_out !== 52'b0)
            report_value("mcr_data_out idle", 64'b0, {12'b0, mcr_data_out});
         if (sdram_ready) begin
            checks++;
            if (sdram_data_out !== expected_read(sdram_map(sdram_addr)))
               report_value("sdram_data_out", {32'b0, expected_read(sdram_map(sdram_addr))},
                            {32'b0, sdram_data_out});
         end else if (sdram_data_out !== 32'b0) begin
            report_value("sdram_data_out idle", 64'b0, {32'b0, sdram_data_out});
         end
         if (vram_ready) begin
            checks++;
            if (vram_data_out !== expected_read(vram_map(vram_addr)))
               report_value("vram_data_out", {32'b0, expected_read(vram_map(vram_addr))},
                            {32'b0, vram_data_out});
         end else if (vram_data_out !== 32'b0) begin
            report_value("vram_data_out idle", 64'b0, {32'b0, vram_data_out});
         end
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("run stopped, cycle limit of %0d reached", CYCLE_LIMIT);
         $display("Testbench failed");
         $finish;
      end
   end

   task automatic mcr_write_op(input logic [11:0] a, input logic [51:0] d);
      int n;
      n = 0;
      @(posedge clk);
      mcr_addr <= a;
      mcr_data_in <= d;
      mcr_write <= 1'b1;
      @(negedge clk);
      while (!mcr_done && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (!mcr_done) begin
         $display("%s: mcr_done never arrived", test_name);
         errors++;
      end else begin
         mcr_order = event_seq;
         event_seq++;
      end
      @(posedge clk);
      mcr_write <= 1'b0;
      // Second beat is written in the following cycle
      @(posedge clk);
      shadow[mcr_map(a, 1'b0)] = {12'b0, d[51:32]};
      shadow[mcr_map(a, 1'b1)] = d[31:0];
   endtask

   task automatic mcr_read_op(input logic [11:0] a);
      int n;
      n = 0;
      @(posedge clk);
      mcr_addr <= a;
      // First ready may belong to the old address
      @(negedge clk);
      while (!mcr_ready && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      @(posedge clk);
      mcr_check_en = 1'b1;
      n = 0;
      @(negedge clk);
      while (!mcr_ready && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (!mcr_ready) begin
         $display("%s: mcr_ready never arrived", test_name);
         errors++;
      end
      @(posedge clk);
      mcr_check_en = 1'b0;
   endtask

   task automatic sdram_op(input logic wr, input logic [17:0] a, input logic [31:0] d);
      int n;
      n = 0;
      @(posedge clk);
      sdram_addr <= a;
      sdram_data_in <= d;
      if (wr) sdram_write <= 1'b1;
      else sdram_req <= 1'b1;
      @(negedge clk);
      while (!(wr ? sdram_done : sdram_ready) && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (!(wr ? sdram_done : sdram_ready)) begin
         $display("%s: sdram strobe never arrived", test_name);
         errors++;
      end else begin
         sdram_order = event_seq;
         event_seq++;
         if (wr) shadow[sdram_map(a)] = d;
      end
      @(posedge clk);
      sdram_write <= 1'b0;
      sdram_req <= 1'b0;
   endtask

   task automatic vram_op(input logic wr, input logic [14:0] a, input logic [31:0] d);
      int n;
      n = 0;
      @(posedge clk);
      vram_addr <= a;
      vram_data_in <= d;
      if (wr) vram_write <= 1'b1;
      else vram_req <= 1'b1;
      @(negedge clk);
      while (!(wr ? vram_done : vram_ready) && n < WAIT_MAX) begin
         @(negedge clk);
         n++;
      end
      if (!(wr ? vram_done : vram_ready)) begin
         $display("%s: vram strobe never arrived", test_name);
         errors++;
      end else begin
         vram_order = event_seq;
         event_seq++;
         if (wr) shadow[vram_map(a)] = d;
      end
      @(posedge clk);
      vram_write <= 1'b0;
      vram_req <= 1'b0;
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err_start = errors;
   endtask

   task automatic end_test;
      $display("test %s finished with %0d errors", test_name, errors - test_err_start);
   endtask

   task automatic idle_cadence;
      int last_ready;
      int ready_count;
      logic [1:0] ce_hist;
      last_ready = -1;
      ready_count = 0;
      ce_hist = 2'b11;
      for (int c = 0; c < 30; c++) begin
         @(negedge clk);
         if (mcr_done || sdram_done || vram_done || sdram_ready || vram_ready) begin
            $display("%s: unexpected strobe with no request at cycle %0d", test_name, c);
            errors++;
         end
         if (mcr_ready) begin
            if (last_ready >= 0 && c - last_ready != 3)
               report_value("ready spacing", 64'd3, 64'(c - last_ready));
            if (ce_hist[1] !== 1'b1)
               report_value("chip enable before RD1", 64'd1, {63'b0, ce_hist[1]});
            last_ready = c;
            ready_count++;
         end
         ce_hist = {ce_hist[0], sram1_ce_n & sram2_ce_n};
      end
      // Thirty cycles at one ready per three
      if (ready_count != 10)
         report_value("ready count", 64'd10, 64'(ready_count));
   endtask

   initial begin
      logic [17:0] av;
      logic [51:0] words [0:7];
      logic [2:0]  op;
      clk = 1'b0;
      reset = 1'b1;
      mcr_addr = '0;
      mcr_data_in = '0;
      mcr_write = 1'b0;
      sdram_addr = '0;
      sdram_data_in = '0;
      sdram_req = 1'b0;
      sdram_write = 1'b0;
      vram_addr = '0;
      vram_data_in = '0;
      vram_req = 1'b0;
      vram_write = 1'b0;
      mcr_check_en = 1'b0;
      seed = 32'h1d0618c3;
      errors = 0;
      checks = 0;
      cycle_count = 0;
      event_seq = 0;
      for (int i = 0; i < 262144; i++) begin
         av = i[17:0];
         shadow[i] = {{av[1:0], av[15:2]} ^ {14'h0, av[17:16]} ^ 16'ha5c3,
                      av[15:0] ^ {av[17:16], 14'h0}};
      end
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      start_test("idle_cadence");
      idle_cadence();
      end_test();

      start_test("mcr_round_trip");
      for (int i = 0; i < 8; i++) begin
         words[i] = 52'({$random(seed), $random(seed)});
         mcr_write_op(12'(i * 37 + 5), words[i]);
      end
      for (int i = 0; i < 8; i++) mcr_read_op(12'(i * 37 + 5));
      end_test();

      start_test("word_regions");
      sdram_op(1'b1, 18'h00123, 32'h1111_2222);
      vram_op(1'b1, 15'h0123, 32'h3333_4444);
      mcr_write_op(12'h123, 52'hA_5555_6666_7777);
      sdram_op(1'b1, 18'h30456, 32'h8888_9999);
      vram_op(1'b1, 15'h7456, 32'hAAAA_BBBB);
      sdram_op(1'b0, 18'h00123, 32'h0);
      vram_op(1'b0, 15'h0123, 32'h0);
      mcr_read_op(12'h123);
      sdram_op(1'b0, 18'h00456, 32'h0);
      vram_op(1'b0, 15'h7456, 32'h0);
      sdram_op(1'b0, 18'h08123, 32'h0);
      vram_op(1'b0, 15'h0456, 32'h0);
      end_test();

      start_test("priority");
      event_seq = 0;
      mcr_order = -1;
      sdram_order = -1;
      vram_order = -1;
      fork
         mcr_write_op(12'h0F0, 52'h1_2345_6789_ABCD);
         sdram_op(1'b0, 18'h00123, 32'h0);
         vram_op(1'b1, 15'h0200, 32'hCAFE_F00D);
      join
      if (mcr_order != 0 || sdram_order != 1 || vram_order != 2)
         report_value("service order", 64'h000102, 64'((mcr_order << 16) |
                      (sdram_order << 8) | vram_order));
      end_test();

      start_test("random_mixed");
      for (int i = 0; i < 200; i++) begin
         op = 3'($unsigned($random(seed)) % 6);
         case (op)
            3'd0: mcr_write_op(12'($random(seed)) & 12'h01F,
                               52'({$random(seed), $random(seed)}));
            3'd1: mcr_read_op(12'($random(seed)) & 12'h01F);
            3'd2: sdram_op(1'b1, 18'($random(seed)) & 18'h3001F, $random(seed));
            3'd3: sdram_op(1'b0, 18'($random(seed)) & 18'h3001F, 32'h0);
            3'd4: vram_op(1'b1, 15'($random(seed)) & 15'h001F, $random(seed));
            default: vram_op(1'b0, 15'($random(seed)) & 15'h001F, 32'h0);
         endcase
      end
      end_test();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* sim.f */
logic/ram_ctrl_pkg.sv
logic/slot_scheduler.sv
logic/mcr_beat_unit.sv
logic/word_port_unit.sv
logic/sram_bus_combiner.sv
logic/ram_controller.sv
tb/sram_model.sv
tb/ram_controller_tb.sv

/* Makefile */
# Verilator flow for the shared SRAM controller

VERILATOR ?= verilator
TOP       ?= ram_controller_tb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
